//--- fp_pkg.sv
package fp_pkg;

   // single precision field widths.
   localparam int EXP_W  = 8;
   localparam int FRAC_W = 23;
   localparam int WORD_W = 1 + EXP_W + FRAC_W;

   // carry position, hidden bit, stored fraction and one sticky guard bit.
   localparam int SUM_W = FRAC_W + 3;

   // rounding modes, riscv frm encoding.
   localparam logic [2:0] RNE = 3'd0;  // nearest, ties to even.
   localparam logic [2:0] RTZ = 3'd1;  // toward zero.
   localparam logic [2:0] RDN = 3'd2;  // toward minus infinity.
   localparam logic [2:0] RUP = 3'd3;  // toward plus infinity.
   localparam logic [2:0] RMM = 3'd4;  // nearest, ties away from zero.

   // largest exponent that still encodes a normal number.
   localparam logic [EXP_W-1:0] EXP_MAX_NORMAL = 8'd254;

   localparam logic [WORD_W-1:0] QNAN    = 32'h7fc0_0000;  // canonical quiet nan.
   localparam logic [WORD_W-1:0] POS_INF = 32'h7f80_0000;  // sign bit clear.

   // an overflow saturates to infinity unless the mode rounds toward zero
   // for this sign, in which case the largest finite value comes out.
   function automatic logic ovf_to_inf(input logic [2:0] mode, input logic sign);
      case (mode)
         RTZ:     return 1'b0;
         RDN:     return sign;
         RUP:     return ~sign;
         default: return 1'b1;
      endcase
   endfunction

endpackage

//--- left_shift.sv
`timescale 1ns/1ns

module left_shift #(
   parameter int W     = fp_pkg::SUM_W,
   parameter int AMT_W = fp_pkg::EXP_W
) (
   input  logic [W-1:0]     fraction,
   output logic [W-1:0]     result,
   output logic [AMT_W-1:0] shifted_amount
);

   // the hidden bit sits one below the carry position.
   always_comb begin
      shifted_amount = '1;  // all zero input.
      // scan upward so the highest set bit wins.
      for (int i = 0; i < W - 1; i++) begin
         if (fraction[i]) begin
            shifted_amount = AMT_W'(W - 2 - i);
         end
      end
      result = fraction << shifted_amount;
   end

endmodule

//--- rounder.sv
`timescale 1ns/1ns

module rounder #(
   parameter int EXP_W  = fp_pkg::EXP_W,
   parameter int FRAC_W = fp_pkg::FRAC_W
) (
   input  logic [2:0]            frm,
   input  logic                  sign,
   input  logic [EXP_W-1:0]      exp_in,
   input  logic [FRAC_W+1:0]     fraction,
   output logic [EXP_W+FRAC_W:0] round_out,
   output logic                  rounded
);
   import fp_pkg::*;

   logic              guard;
   logic              lsb;
   logic              inc;
   logic              frac_carry;
   logic [FRAC_W-1:0] frac_kept;
   logic [EXP_W-1:0]  exp_out;

   always_comb begin
      guard = fraction[0];  // sticky already folded in.
      lsb   = fraction[1];

      case (frm)
         RNE:     inc = guard & lsb;  // guard set counts as a tie.
         RTZ:     inc = 1'b0;
         RDN:     inc = guard & sign;
         RUP:     inc = guard & ~sign;
         RMM:     inc = guard;
         default: inc = 1'b0;  // reserved modes truncate.
      endcase

      {frac_carry, frac_kept} = {1'b0, fraction[FRAC_W:1]} + inc;

      // no hidden bit means the value is zero.
      if (fraction[FRAC_W+1]) begin
         exp_out = exp_in + frac_carry;
      end else begin
         exp_out = '0;
      end

      round_out = {sign, exp_out, frac_kept};
      rounded   = guard;
   end

endmodule

//--- fp_add_step1.sv
`timescale 1ns/1ns

module fp_add_step1 #(
   parameter int EXP_W  = fp_pkg::EXP_W,
   parameter int FRAC_W = fp_pkg::FRAC_W,
   parameter int SUM_W  = fp_pkg::SUM_W
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  in_valid,
   input  logic [EXP_W+FRAC_W:0] a,
   input  logic [EXP_W+FRAC_W:0] b,
   input  logic                  op_sub,
   input  logic [2:0]            frm,
   output logic                  s1_valid,
   output logic [EXP_W-1:0]      exp_max,
   output logic [SUM_W-1:0]      frac_big,
   output logic [SUM_W-1:0]      frac_small,
   output logic                  sign_big,
   output logic                  eff_sub,
   output logic                  inv,
   output logic                  special_inf,
   output logic                  inf_sign,
   output logic [2:0]            frm_q
);
   logic              sign_a, sign_b;
   logic [EXP_W-1:0]  exp_a, exp_b;
   logic [FRAC_W-1:0] man_a, man_b;
   logic              nan_a, nan_b, inf_a, inf_b;
   logic              a_big;
   logic [EXP_W-1:0]  exp_max_c, exp_small, exp_diff;
   logic [SUM_W-1:0]  big_c, small_full, small_shr, lost_mask, small_c;
   logic              sign_big_c, inv_c, special_inf_c, inf_sign_c;

   always_comb begin
      sign_a = a[EXP_W+FRAC_W];
      sign_b = b[EXP_W+FRAC_W] ^ op_sub;  // subtract flips b.
      exp_a  = a[EXP_W+FRAC_W-1:FRAC_W];
      exp_b  = b[EXP_W+FRAC_W-1:FRAC_W];
      // subnormal inputs read as zero.
      man_a  = (exp_a == '0) ? '0 : a[FRAC_W-1:0];
      man_b  = (exp_b == '0) ? '0 : b[FRAC_W-1:0];

      nan_a = (exp_a == '1) && (man_a != '0);
      nan_b = (exp_b == '1) && (man_b != '0);
      inf_a = (exp_a == '1) && (man_a == '0);
      inf_b = (exp_b == '1) && (man_b == '0);

      inv_c         = nan_a | nan_b | (inf_a & inf_b & (sign_a ^ sign_b));
      special_inf_c = ~inv_c & (inf_a | inf_b);
      inf_sign_c    = inf_a ? sign_a : sign_b;  // both inf means same sign here.

      // larger magnitude goes first.
      a_big = {exp_a, man_a} >= {exp_b, man_b};
      if (a_big) begin
         exp_max_c  = exp_a;
         exp_small  = exp_b;
         sign_big_c = sign_a;
         big_c      = {1'b0, exp_a != '0, man_a, 1'b0};
         small_full = {1'b0, exp_b != '0, man_b, 1'b0};
      end else begin
         exp_max_c  = exp_b;
         exp_small  = exp_a;
         sign_big_c = sign_b;
         big_c      = {1'b0, exp_b != '0, man_b, 1'b0};
         small_full = {1'b0, exp_a != '0, man_a, 1'b0};
      end

      // align, folding everything shifted out into the guard bit.
      exp_diff  = exp_max_c - exp_small;
      small_shr = small_full >> exp_diff;
      lost_mask = ~({SUM_W{1'b1}} << exp_diff);
      small_c   = {small_shr[SUM_W-1:1], small_shr[0] | (|(small_full & lost_mask))};
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      exp_max     <= exp_max_c;
      frac_big    <= big_c;
      frac_small  <= small_c;
      sign_big    <= sign_big_c;
      eff_sub     <= sign_a ^ sign_b;
      inv         <= inv_c;
      special_inf <= special_inf_c;
      inf_sign    <= inf_sign_c;
      frm_q       <= frm;
   end

endmodule

//--- fp_add_step2.sv
`timescale 1ns/1ns

module fp_add_step2 #(
   parameter int EXP_W = fp_pkg::EXP_W,
   parameter int SUM_W = fp_pkg::SUM_W
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             s1_valid,
   input  logic [EXP_W-1:0] exp_max,
   input  logic [SUM_W-1:0] frac_big,
   input  logic [SUM_W-1:0] frac_small,
   input  logic             sign_big,
   input  logic             eff_sub,
   input  logic             inv,
   input  logic             special_inf,
   input  logic             inf_sign,
   input  logic [2:0]       frm_q,
   output logic             s2_valid,
   output logic [EXP_W-1:0] exp_max_q,
   output logic [SUM_W-1:0] frac_sum,
   output logic             carry_out,
   output logic             sign_res,
   output logic             inv_q,
   output logic             special_inf_q,
   output logic             inf_sign_q,
   output logic [2:0]       frm_qq
);
   import fp_pkg::*;

   logic [SUM_W-1:0] sum_c;
   logic             sign_c;

   always_comb begin
      // big is never below small, so the difference cannot wrap.
      if (eff_sub) begin
         sum_c = frac_big - frac_small;
      end else begin
         sum_c = frac_big + frac_small;
      end

      // exact cancellation gives +0, or -0 when rounding down.
      if (eff_sub && (sum_c == '0)) begin
         sign_c = (frm_q == RDN);
      end else begin
         sign_c = sign_big;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s2_valid <= 1'b0;
      end else begin
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      exp_max_q     <= exp_max;
      frac_sum      <= sum_c;
      carry_out     <= sum_c[SUM_W-1];  // top bit is the carry position.
      sign_res      <= sign_c;
      inv_q         <= inv;
      special_inf_q <= special_inf;
      inf_sign_q    <= inf_sign;
      frm_qq        <= frm_q;
   end

endmodule

//--- fp_add_step3.sv
`timescale 1ns/1ns

module fp_add_step3 #(
   parameter int EXP_W  = fp_pkg::EXP_W,
   parameter int FRAC_W = fp_pkg::FRAC_W,
   parameter int SUM_W  = fp_pkg::SUM_W
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  s2_valid,
   input  logic [EXP_W-1:0]      exp_max_in,
   input  logic [SUM_W-1:0]      frac_in,
   input  logic                  carry_out,
   input  logic                  sign_in,
   input  logic                  inv_in,
   input  logic                  special_inf,
   input  logic                  inf_sign,
   input  logic [2:0]            frm,
   output logic                  out_valid,
   output logic [EXP_W+FRAC_W:0] result,
   output logic                  ovf,
   output logic                  unf,
   output logic                  inexact,
   output logic                  inv
);
   import fp_pkg::*;

   logic [SUM_W-1:0]      shifted_frac;
   logic [EXP_W-1:0]      shifted_amount;
   logic [FRAC_W+1:0]     round_this;
   logic [EXP_W-1:0]      exp_out;
   logic [EXP_W+FRAC_W:0] round_out;
   logic                  rounded;
   logic                  is_zero, ovf_c, unf_c, rnd_ovf;
   logic [EXP_W+FRAC_W:0] result_c;
   logic                  ovf_f, unf_f, inexact_f;

   left_shift #(.W(SUM_W), .AMT_W(EXP_W)) shift_left (
      .fraction       (frac_in),
      .result         (shifted_frac),
      .shifted_amount (shifted_amount)
   );

   always_comb begin
      is_zero = (frac_in == '0);
      ovf_c   = 1'b0;
      unf_c   = 1'b0;
      if (carry_out) begin
         // drop one bit into the guard and bump the exponent.
         round_this = {frac_in[SUM_W-1:2], frac_in[1] | frac_in[0]};
         exp_out    = exp_max_in + 1'b1;
         ovf_c      = (exp_max_in == EXP_MAX_NORMAL);
      end else begin
         round_this = shifted_frac[SUM_W-2:0];
         exp_out    = exp_max_in - shifted_amount;
         unf_c      = ~is_zero & (shifted_amount >= exp_max_in);  // flush subnormals.
      end
   end

   rounder #(.EXP_W(EXP_W), .FRAC_W(FRAC_W)) round_unit (
      .frm       (frm),
      .sign      (sign_in),
      .exp_in    (exp_out),
      .fraction  (round_this),
      .round_out (round_out),
      .rounded   (rounded)
   );

   always_comb begin
      // rounding up past the largest normal.
      rnd_ovf   = (round_out[EXP_W+FRAC_W-1:FRAC_W] == '1) & ~unf_c & ~is_zero;
      ovf_f     = ovf_c | rnd_ovf;
      unf_f     = unf_c;
      inexact_f = ovf_f | unf_f | rounded;

      if (inv_in) begin
         result_c  = QNAN;
         ovf_f     = 1'b0;
         unf_f     = 1'b0;
         inexact_f = 1'b0;
      end else if (special_inf) begin
         result_c  = {inf_sign, POS_INF[EXP_W+FRAC_W-1:0]};
         ovf_f     = 1'b0;
         unf_f     = 1'b0;
         inexact_f = 1'b0;
      end else if (ovf_f) begin
         if (ovf_to_inf(frm, sign_in)) begin
            result_c = {sign_in, POS_INF[EXP_W+FRAC_W-1:0]};
         end else begin
            result_c = {sign_in, EXP_MAX_NORMAL, {FRAC_W{1'b1}}};
         end
      end else if (unf_f || is_zero) begin
         result_c = {sign_in, {(EXP_W+FRAC_W){1'b0}}};
      end else begin
         result_c = round_out;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         result    <= '0;
         ovf       <= 1'b0;
         unf       <= 1'b0;
         inexact   <= 1'b0;
         inv       <= 1'b0;
      end else begin
         out_valid <= s2_valid;
         if (s2_valid) begin  // hold between operations.
            result  <= result_c;
            ovf     <= ovf_f;
            unf     <= unf_f;
            inexact <= inexact_f;
            inv     <= inv_in;
         end
      end
   end

endmodule

//--- fp_add_top.sv
`timescale 1ns/1ns

module fp_add_top #(
   parameter int EXP_W  = fp_pkg::EXP_W,
   parameter int FRAC_W = fp_pkg::FRAC_W,
   parameter int SUM_W  = fp_pkg::SUM_W
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  in_valid,
   input  logic [EXP_W+FRAC_W:0] a,
   input  logic [EXP_W+FRAC_W:0] b,
   input  logic                  op_sub,
   input  logic [2:0]            frm,
   output logic                  out_valid,
   output logic [EXP_W+FRAC_W:0] result,
   output logic                  ovf,
   output logic                  unf,
   output logic                  inexact,
   output logic                  inv
);
   // step 1 to step 2.
   logic             s1_valid;
   logic [EXP_W-1:0] s1_exp_max;
   logic [SUM_W-1:0] s1_frac_big, s1_frac_small;
   logic             s1_sign_big, s1_eff_sub;
   logic             s1_inv, s1_special_inf, s1_inf_sign;
   logic [2:0]       s1_frm;

   // step 2 to step 3.
   logic             s2_valid;
   logic [EXP_W-1:0] s2_exp_max;
   logic [SUM_W-1:0] s2_frac_sum;
   logic             s2_carry_out, s2_sign_res;
   logic             s2_inv, s2_special_inf, s2_inf_sign;
   logic [2:0]       s2_frm;

   fp_add_step1 #(.EXP_W(EXP_W), .FRAC_W(FRAC_W), .SUM_W(SUM_W)) step1 (
      .clk (clk), .rst_n (rst_n), .in_valid (in_valid),
      .a (a), .b (b), .op_sub (op_sub), .frm (frm),
      .s1_valid (s1_valid), .exp_max (s1_exp_max),
      .frac_big (s1_frac_big), .frac_small (s1_frac_small),
      .sign_big (s1_sign_big), .eff_sub (s1_eff_sub), .inv (s1_inv),
      .special_inf (s1_special_inf), .inf_sign (s1_inf_sign), .frm_q (s1_frm)
   );

   fp_add_step2 #(.EXP_W(EXP_W), .SUM_W(SUM_W)) step2 (
      .clk (clk), .rst_n (rst_n), .s1_valid (s1_valid), .exp_max (s1_exp_max),
      .frac_big (s1_frac_big), .frac_small (s1_frac_small),
      .sign_big (s1_sign_big), .eff_sub (s1_eff_sub), .inv (s1_inv),
      .special_inf (s1_special_inf), .inf_sign (s1_inf_sign), .frm_q (s1_frm),
      .s2_valid (s2_valid), .exp_max_q (s2_exp_max), .frac_sum (s2_frac_sum),
      .carry_out (s2_carry_out), .sign_res (s2_sign_res), .inv_q (s2_inv),
      .special_inf_q (s2_special_inf), .inf_sign_q (s2_inf_sign), .frm_qq (s2_frm)
   );

   fp_add_step3 #(.EXP_W(EXP_W), .FRAC_W(FRAC_W), .SUM_W(SUM_W)) step3 (
      .clk (clk), .rst_n (rst_n), .s2_valid (s2_valid),
      .exp_max_in (s2_exp_max), .frac_in (s2_frac_sum), .carry_out (s2_carry_out),
      .sign_in (s2_sign_res), .inv_in (s2_inv), .special_inf (s2_special_inf),
      .inf_sign (s2_inf_sign), .frm (s2_frm),
      .out_valid (out_valid), .result (result), .ovf (ovf), .unf (unf),
      .inexact (inexact), .inv (inv)
   );

endmodule

//--- tb_fp_add.sv
`timescale 1ns/1ns

module tb_fp_add;
   import fp_pkg::*;

   localparam int RESET_CYCLES = 8;
   localparam int LATENCY      = 3;

   logic        clk;
   logic        rst_n;
   logic        in_valid;
   logic [31:0] a;
   logic [31:0] b;
   logic        op_sub;
   logic [2:0]  frm;
   logic        out_valid;
   logic [31:0] result;
   logic        ovf;
   logic        unf;
   logic        inexact;
   logic        inv;

   // vector table kept as parallel queues.
   string       vec_name[$];
   logic [31:0] vec_a[$];
   logic [31:0] vec_b[$];
   logic        vec_sub[$];
   logic [2:0]  vec_frm[$];
   logic [31:0] vec_res[$];
   logic [3:0]  vec_flags[$];  // ovf, unf, inexact, inv.

   int pend_idx[$];    // table entries in flight.
   int pend_cycle[$];  // cycle each one was driven.

   int cycle      = 0;
   int max_cycles = 0;
   int pass_count = 0;
   int fail_count = 0;
   int errors     = 0;  // mismatches in the current test.

   fp_add_top dut0 (
      .clk (clk), .rst_n (rst_n), .in_valid (in_valid), .a (a), .b (b),
      .op_sub (op_sub), .frm (frm), .out_valid (out_valid), .result (result),
      .ovf (ovf), .unf (unf), .inexact (inexact), .inv (inv)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (max_cycles > 0 && cycle > max_cycles) begin
         $display("timeout after %0d cycles, %0d operations still in flight",
                  cycle, pend_idx.size());
         $display("TEST FAIL");
         $finish;
      end
   end

   task automatic add_vector(input string name, input logic [31:0] op_a,
                             input logic [31:0] op_b, input logic sub,
                             input logic [2:0] mode, input logic [31:0] res,
                             input logic [3:0] flags);
      vec_name.push_back(name);
      vec_a.push_back(op_a);
      vec_b.push_back(op_b);
      vec_sub.push_back(sub);
      vec_frm.push_back(mode);
      vec_res.push_back(res);
      vec_flags.push_back(flags);
   endtask

   // flags column is {ovf, unf, inexact, inv}.
   task automatic load_table();
      add_vector("add_1_2",       32'h3f80_0000, 32'h4000_0000, 1'b0, RNE, 32'h4040_0000, 4'b0000);
      add_vector("add_1_1",       32'h3f80_0000, 32'h3f80_0000, 1'b0, RNE, 32'h4000_0000, 4'b0000);
      add_vector("sub_5_5_rne",   32'h40a0_0000, 32'h40a0_0000, 1'b1, RNE, 32'h0000_0000, 4'b0000);
      add_vector("sub_5_5_rdn",   32'h40a0_0000, 32'h40a0_0000, 1'b1, RDN, 32'h8000_0000, 4'b0000);
      add_vector("sub_1_3",       32'h3f80_0000, 32'h4040_0000, 1'b1, RNE, 32'hc000_0000, 4'b0000);
      add_vector("sub_1_0p75",    32'h3f80_0000, 32'h3f40_0000, 1'b1, RNE, 32'h3e80_0000, 4'b0000);
      add_vector("add_1p5_m0p25", 32'h3fc0_0000, 32'hbe80_0000, 1'b0, RNE, 32'h3fa0_0000, 4'b0000);
      add_vector("tie_rne",       32'h3f80_0000, 32'h3380_0000, 1'b0, RNE, 32'h3f80_0000, 4'b0010);
      add_vector("tie_rtz",       32'h3f80_0000, 32'h3380_0000, 1'b0, RTZ, 32'h3f80_0000, 4'b0010);
      add_vector("tie_rdn",       32'h3f80_0000, 32'h3380_0000, 1'b0, RDN, 32'h3f80_0000, 4'b0010);
      add_vector("tie_rup",       32'h3f80_0000, 32'h3380_0000, 1'b0, RUP, 32'h3f80_0001, 4'b0010);
      add_vector("tie_rmm",       32'h3f80_0000, 32'h3380_0000, 1'b0, RMM, 32'h3f80_0001, 4'b0010);
      add_vector("tie_neg_rdn",   32'hbf80_0000, 32'h3380_0000, 1'b1, RDN, 32'hbf80_0001, 4'b0010);
      add_vector("tie_neg_rup",   32'hbf80_0000, 32'h3380_0000, 1'b1, RUP, 32'hbf80_0000, 4'b0010);
      add_vector("sticky_rup",    32'h3f80_0000, 32'h3300_0000, 1'b0, RUP, 32'h3f80_0001, 4'b0010);
      add_vector("carry_rup",     32'h3f80_0001, 32'h3f80_0000, 1'b0, RUP, 32'h4000_0001, 4'b0010);
      add_vector("ovf_max_rne",   32'h7f7f_ffff, 32'h7f7f_ffff, 1'b0, RNE, 32'h7f80_0000, 4'b1010);
      add_vector("ovf_max_rtz",   32'h7f7f_ffff, 32'h7f7f_ffff, 1'b0, RTZ, 32'h7f7f_ffff, 4'b1010);
      add_vector("ovf_half_rup",  32'h7f7f_ffff, 32'h7380_0000, 1'b0, RUP, 32'h7f80_0000, 4'b1010);
      add_vector("unf_neg",       32'h0080_0000, 32'h0080_0001, 1'b1, RNE, 32'h8000_0000, 4'b0110);
      add_vector("unf_pos",       32'h0080_0001, 32'h0080_0000, 1'b1, RNE, 32'h0000_0000, 4'b0110);
      add_vector("qnan_in",       32'h7fc0_0000, 32'h3f80_0000, 1'b0, RNE, QNAN,          4'b0001);
      add_vector("snan_in",       32'h3f80_0000, 32'h7f80_0001, 1'b0, RNE, QNAN,          4'b0001);
      add_vector("inf_sub_inf",   32'h7f80_0000, 32'h7f80_0000, 1'b1, RNE, QNAN,          4'b0001);
      add_vector("inf_add_1",     32'h7f80_0000, 32'h3f80_0000, 1'b0, RNE, 32'h7f80_0000, 4'b0000);
      add_vector("one_sub_inf",   32'h3f80_0000, 32'h7f80_0000, 1'b1, RNE, 32'hff80_0000, 4'b0000);
   endtask

   task automatic compare(input string test, input string what,
                          input logic [31:0] expected, input logic [31:0] actual);
      if (actual !== expected) begin
         $display("FAILED %s %s expected %h actual %h", test, what, expected, actual);
         errors++;
      end
   endtask

   task automatic tally(input string name);
      if (errors == 0) begin
         pass_count++;
         $display("passed %s", name);
      end else begin
         fail_count++;
      end
   endtask

   task automatic check_output();
      int idx;
      int issued;
      if (pend_idx.size() == 0) begin
         $display("out_valid high at cycle %0d with no operation in flight", cycle);
         fail_count++;
      end else begin
         idx    = pend_idx.pop_front();
         issued = pend_cycle.pop_front();
         errors = 0;
         compare(vec_name[idx], "result", vec_res[idx], result);
         compare(vec_name[idx], "flags", {28'd0, vec_flags[idx]},
                 {28'd0, ovf, unf, inexact, inv});
         compare(vec_name[idx], "latency", LATENCY, 32'(cycle - issued));
         tally(vec_name[idx]);
      end
   endtask

   // outputs are settled by the falling edge.
   always @(negedge clk) begin
      if (rst_n === 1'b1 && out_valid === 1'b1) begin
         check_output();
      end
   end

   task automatic issue(input int idx);
      @(posedge clk);
      #2;
      in_valid = 1'b1;
      a        = vec_a[idx];
      b        = vec_b[idx];
      op_sub   = vec_sub[idx];
      frm      = vec_frm[idx];
      pend_idx.push_back(idx);
      pend_cycle.push_back(cycle);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
         in_valid = 1'b0;
      end
   endtask

   task automatic drain();
      for (int k = 0; k < 2 * LATENCY && pend_idx.size() != 0; k++) begin
         @(negedge clk);
      end
      if (pend_idx.size() != 0) begin
         $display("%0d operations never came out of the pipeline", pend_idx.size());
         fail_count++;
         pend_idx.delete();
         pend_cycle.delete();
      end
   endtask

   initial begin
      int idx;
      int gap;
      void'($urandom(55589));
      rst_n    = 1'b0;
      in_valid = 1'b0;
      a        = '0;
      b        = '0;
      op_sub   = 1'b0;
      frm      = RNE;
      load_table();
      max_cycles = RESET_CYCLES + 2 * vec_name.size() * 6;

      // outputs must sit at zero while reset is held.
      repeat (4) @(negedge clk);
      errors = 0;
      compare("reset", "result", 32'd0, result);
      compare("reset", "valid and flags", 32'd0, {27'd0, out_valid, ovf, unf, inexact, inv});
      tally("reset");
      repeat (RESET_CYCLES - 4) @(posedge clk);
      #2;
      rst_n = 1'b1;

      for (int i = 0; i < vec_name.size(); i++) begin
         issue(i);  // back to back.
      end
      idle(1);
      drain();

      for (int n = 0; n < vec_name.size(); n++) begin
         idx = int'($urandom % vec_name.size());
         gap = int'($urandom % 4);
         issue(idx);
         idle(gap);
      end
      idle(1);
      drain();

      $display("summary: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- vlog.f
fp_pkg.sv
left_shift.sv
rounder.sv
fp_add_step1.sv
fp_add_step2.sv
fp_add_step3.sv
fp_add_top.sv
tb_fp_add.sv

//--- Makefile
# Verilator build and run for the floating-point adder testbench.
VERILATOR ?= verilator
TOP       ?= tb_fp_add
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
